/* src/memTag_settings.svh */
// Memory tag access stage widths and counts
// Shared by the package, the lanes and the top level

`ifndef MEM_TAG_SETTINGS_SVH
`define MEM_TAG_SETTINGS_SVH

// Address and data path
`define MT_ADDR_WIDTH 32

// Active list with 64 entries
`define MT_AL_PTR_WIDTH 6

// Miss status holding registers
`define MT_MSHR_NUM 4
`define MT_MSHR_ID_WIDTH 2

// Data cache line offset and replay index subset
`define MT_LINE_BYTE_BITS 4
`define MT_INDEX_SUBSET_BITS 3

`endif

/* src/MemTagPkg.sv */
// Types for the memory tag access stage
// Opcodes, execution states and the structs passed between stages

`include "memTag_settings.svh"

package MemTagPkg;

    typedef enum logic [2:0] {
        MOP_LOAD, MOP_STORE, MOP_ENV, MOP_FENCE, MOP_OTHER
    } memOpType_e;

    typedef enum logic [2:0] {
        ENV_BREAK, ENV_CALL, ENV_MRET, ENV_ILLEGAL, ENV_VIOLATION
    } envCode_e;

    typedef enum logic [3:0] {
        NOT_FINISHED, SUCCESS, REFETCH_THIS, REFETCH_NEXT,
        TRAP_EBREAK, TRAP_ECALL, TRAP_MRET,
        FAULT_INSN_ILLEGAL, FAULT_INSN_VIOLATION,
        FAULT_LOAD_MISALIGNED, FAULT_LOAD_VIOLATION,
        FAULT_STORE_MISALIGNED, FAULT_STORE_VIOLATION
    } execState_e;

    typedef enum logic [1:0] {MMT_MEMORY, MMT_IO, MMT_ILLEGAL} memMapType_e;

    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} accessSize_e;

    // Instruction entering a lane from the execute stage
    typedef struct packed {
        logic valid;
        logic regValid;
        memOpType_e opType;
        envCode_e envCode;
        logic isFenceI;
        accessSize_e size;
        logic [`MT_ADDR_WIDTH-1:0] addr;
        memMapType_e memMapType;
        logic [`MT_AL_PTR_WIDTH-1:0] activeListPtr;
        logic [`MT_ADDR_WIDTH-1:0] pc;
        logic [`MT_ADDR_WIDTH-1:0] data;
        logic hasAllocatedMshr;
        logic [`MT_MSHR_ID_WIDTH-1:0] mshrId;
    } memTagEntry_t;

    typedef struct packed {
        logic toRecoveryPhase;
        logic flushAll;
        logic [`MT_AL_PTR_WIDTH-1:0] headPtr;
        logic [`MT_AL_PTR_WIDTH-1:0] tailPtr;
    } flushRequest_t;

    // Tag check results for the load held in the stage
    typedef struct packed {
        logic storeLoadForwarded;
        logic forwardMiss;
        logic mshrReadHit;
        logic dcReadHit;
        logic mshrAddrHit;
        logic loadHasAllocatedMshr;
        logic [`MT_MSHR_ID_WIDTH-1:0] allocMshrId;
        logic [`MT_MSHR_ID_WIDTH-1:0] hitMshrId;
    } loadTagResult_t;

    typedef struct packed {
        logic valid;
        logic regValid;
        execState_e execState;
        logic isLoad;
        logic isStore;
        logic [`MT_ADDR_WIDTH-1:0] addr;
        logic [`MT_AL_PTR_WIDTH-1:0] activeListPtr;
        logic [`MT_ADDR_WIDTH-1:0] pc;
        logic [`MT_ADDR_WIDTH-1:0] data;
    } memAccessOut_t;

    // Replay queue request
    typedef struct packed {
        logic record;
        logic addrHit;
        logic [`MT_INDEX_SUBSET_BITS-1:0] addrSubset;
        logic hasAllocatedMshr;
        logic [`MT_MSHR_ID_WIDTH-1:0] mshrId;
        logic [`MT_AL_PTR_WIDTH-1:0] activeListPtr;
        logic [`MT_ADDR_WIDTH-1:0] pc;
    } replayRecord_t;

    typedef struct packed {
        logic execute;
        logic [`MT_ADDR_WIDTH-1:0] addr;
        logic [`MT_ADDR_WIDTH-1:0] pc;
        accessSize_e size;
        logic regValid;
    } loadExecReq_t;

    typedef struct packed {
        logic execute;
        logic [`MT_ADDR_WIDTH-1:0] addr;
        logic [`MT_ADDR_WIDTH-1:0] data;
        accessSize_e size;
        logic regValid;
    } storeExecReq_t;

    // Half needs bit 0 clear, word needs both low bits clear
    function automatic logic isMisaligned(
        input logic [`MT_ADDR_WIDTH-1:0] addr,
        input accessSize_e size
    );
        case (size)
            SIZE_HALF: return addr[0];
            SIZE_WORD: return addr[1:0] != 2'b00;
            default:   return 1'b0;
        endcase
    endfunction

endpackage

/* src/FlushRangeCheck.sv */
// Selective flush detector
// Tells whether an active-list pointer lies in the range being flushed

`timescale 1ns/1ns
`include "memTag_settings.svh"

module FlushRangeCheck (
    input  MemTagPkg::flushRequest_t flushReq,
    input  logic [`MT_AL_PTR_WIDTH-1:0] ptr,
    output logic flush
);
    import MemTagPkg::*;

    logic inRange;

    always_comb begin
        // Half-open range [head, tail), wrapping past the list end
        if (flushReq.headPtr <= flushReq.tailPtr) begin
            inRange = (ptr >= flushReq.headPtr) && (ptr < flushReq.tailPtr);
        end else begin
            inRange = (ptr >= flushReq.headPtr) || (ptr < flushReq.tailPtr);
        end
    end

    assign flush = flushReq.toRecoveryPhase && (flushReq.flushAll || inRange);

endmodule

/* src/LoadTagLane.sv */
// Load lane of the memory tag access stage
// Decides load result validity and execution state, requests replays
// and frees MSHR entries held by forwarded or flushed loads

`timescale 1ns/1ns
`include "memTag_settings.svh"

module LoadTagLane (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic clear,
    input  logic flush,
    input  MemTagPkg::memTagEntry_t entryIn,
    input  MemTagPkg::loadTagResult_t tagResult,
    output logic [`MT_AL_PTR_WIDTH-1:0] activeListPtr,
    output MemTagPkg::loadExecReq_t execReq,
    output MemTagPkg::memAccessOut_t out,
    output MemTagPkg::replayRecord_t record,
    output logic [`MT_MSHR_NUM-1:0] mshrRelease
);
    import MemTagPkg::*;

    memTagEntry_t entryReg;
    logic update;
    logic isLoad;
    logic isEnv;
    logic isFenceI;
    logic hasMshr;
    logic [`MT_MSHR_ID_WIDTH-1:0] mshrId;
    logic resultValid;
    logic releaseReq;
    execState_e execState;

    // Only valid is cleared, payload follows it
    always_ff @(posedge clk) begin
        if (!rstN) begin
            entryReg.valid <= 1'b0;
        end else if (!stall) begin
            entryReg <= entryIn;
        end
    end

    assign activeListPtr = entryReg.activeListPtr;
    assign update = entryReg.valid && !stall && !clear && !flush;
    assign isLoad = entryReg.opType == MOP_LOAD;
    assign isEnv = entryReg.opType == MOP_ENV;
    assign isFenceI = (entryReg.opType == MOP_FENCE) && entryReg.isFenceI;
    assign hasMshr = entryReg.hasAllocatedMshr || tagResult.loadHasAllocatedMshr;

    // MSHR the replayed load waits on
    always_comb begin
        if (entryReg.hasAllocatedMshr) begin
            mshrId = entryReg.mshrId;
        end else if (tagResult.loadHasAllocatedMshr) begin
            mshrId = tagResult.allocMshrId;
        end else if (tagResult.mshrAddrHit) begin
            mshrId = tagResult.hitMshrId;
        end else begin
            mshrId = entryReg.mshrId;
        end
    end

    // Data arrival check
    always_comb begin
        if (isLoad) begin
            if (tagResult.storeLoadForwarded) begin
                resultValid = !tagResult.forwardMiss;
            end else if (hasMshr) begin
                resultValid = tagResult.mshrReadHit;
            end else begin
                resultValid = tagResult.mshrReadHit || tagResult.dcReadHit;
            end
            resultValid = resultValid && entryReg.regValid;
        end else if (hasMshr) begin
            resultValid = tagResult.mshrReadHit;
        end else begin
            resultValid = entryReg.regValid;
        end
    end

    always_comb begin
        if (!update || !resultValid) begin
            execState = NOT_FINISHED;
        end else if (isLoad) begin
            if (tagResult.storeLoadForwarded && tagResult.forwardMiss) begin
                execState = REFETCH_THIS;
            end else begin
                execState = SUCCESS;
            end
        end else if (isEnv) begin
            case (entryReg.envCode)
                ENV_BREAK:     execState = TRAP_EBREAK;
                ENV_CALL:      execState = TRAP_ECALL;
                ENV_MRET:      execState = TRAP_MRET;
                ENV_ILLEGAL:   execState = FAULT_INSN_ILLEGAL;
                ENV_VIOLATION: execState = FAULT_INSN_VIOLATION;
                default:       execState = TRAP_EBREAK;
            endcase
        end else if (isFenceI) begin
            // Following fetches may hold stale instruction cache data
            execState = REFETCH_NEXT;
        end else begin
            execState = SUCCESS;
        end

        // Region fault wins over misalignment
        if (isLoad && (execState inside {SUCCESS, REFETCH_NEXT})) begin
            if (entryReg.memMapType == MMT_ILLEGAL) begin
                execState = FAULT_LOAD_VIOLATION;
            end else if (isMisaligned(entryReg.addr, entryReg.size)) begin
                execState = FAULT_LOAD_MISALIGNED;
            end
        end
    end

    always_comb begin
        execReq.execute = update && isLoad;
        execReq.addr = entryReg.addr;
        execReq.pc = entryReg.pc;
        execReq.size = entryReg.size;
        execReq.regValid = resultValid;

        out.valid = update;
        out.regValid = resultValid;
        out.execState = execState;
        out.isLoad = isLoad;
        out.isStore = 1'b0;
        out.addr = entryReg.addr;
        out.activeListPtr = entryReg.activeListPtr;
        out.pc = entryReg.pc;
        out.data = entryReg.data;

        // Missing data goes back to the scheduler
        record.record = update && !resultValid;
        record.addrHit = tagResult.mshrAddrHit;
        record.addrSubset =
            entryReg.addr[`MT_LINE_BYTE_BITS+`MT_INDEX_SUBSET_BITS-1:`MT_LINE_BYTE_BITS];
        record.hasAllocatedMshr = hasMshr;
        record.mshrId = mshrId;
        record.activeListPtr = entryReg.activeListPtr;
        record.pc = entryReg.pc;
    end

    // Forwarded data makes the MSHR useless, as does a flush
    assign releaseReq =
        (update && resultValid && isLoad && tagResult.storeLoadForwarded && hasMshr) ||
        (entryReg.valid && isLoad && flush && hasMshr);

    always_comb begin
        mshrRelease = '0;
        if (releaseReq) begin
            mshrRelease[mshrId] = 1'b1;
        end
    end

    // The flush detector outside must keep a flushed load off the unit
    assert property (@(posedge clk) disable iff (!rstN) !(execReq.execute && flush));

    assert property (@(posedge clk) disable iff (!rstN) $onehot0(mshrRelease));

endmodule

/* src/StoreTagLane.sv */
// Store lane of the memory tag access stage
// Detects memory order violations, store faults and replay requests

`timescale 1ns/1ns
`include "memTag_settings.svh"

module StoreTagLane (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic clear,
    input  logic flush,
    input  MemTagPkg::memTagEntry_t entryIn,
    input  logic conflict,
    output logic [`MT_AL_PTR_WIDTH-1:0] activeListPtr,
    output MemTagPkg::storeExecReq_t execReq,
    output MemTagPkg::memAccessOut_t out,
    output MemTagPkg::replayRecord_t record,
    output logic orderViolation
);
    import MemTagPkg::*;

    memTagEntry_t entryReg;
    logic update;
    logic isStore;
    execState_e execState;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            entryReg.valid <= 1'b0;
        end else if (!stall) begin
            entryReg <= entryIn;
        end
    end

    assign activeListPtr = entryReg.activeListPtr;
    assign update = entryReg.valid && !stall && !clear && !flush;
    assign isStore = entryReg.opType == MOP_STORE;

    // A younger load already read stale data, the store itself is fine
    assign orderViolation = update && entryReg.regValid && isStore && conflict;

    always_comb begin
        if (!update || !entryReg.regValid) begin
            execState = NOT_FINISHED;
        end else if (isStore && conflict) begin
            execState = REFETCH_NEXT;
        end else begin
            execState = SUCCESS;
        end

        if (isStore && (execState inside {SUCCESS, REFETCH_NEXT})) begin
            if (entryReg.memMapType == MMT_ILLEGAL) begin
                execState = FAULT_STORE_VIOLATION;
            end else if (isMisaligned(entryReg.addr, entryReg.size)) begin
                execState = FAULT_STORE_MISALIGNED;
            end
        end
    end

    always_comb begin
        execReq.execute = update && isStore;
        execReq.addr = entryReg.addr;
        execReq.data = entryReg.data;
        execReq.size = entryReg.size;
        execReq.regValid = entryReg.regValid;

        out.valid = update;
        out.regValid = entryReg.regValid;
        out.execState = execState;
        out.isLoad = 1'b0;
        out.isStore = isStore;
        out.addr = entryReg.addr;
        out.activeListPtr = entryReg.activeListPtr;
        out.pc = entryReg.pc;
        out.data = entryReg.data;

        // Stores never wait on an MSHR
        record.record = update && !entryReg.regValid;
        record.addrHit = 1'b0;
        record.addrSubset =
            entryReg.addr[`MT_LINE_BYTE_BITS+`MT_INDEX_SUBSET_BITS-1:`MT_LINE_BYTE_BITS];
        record.hasAllocatedMshr = 1'b0;
        record.mshrId = '0;
        record.activeListPtr = entryReg.activeListPtr;
        record.pc = entryReg.pc;
    end

    assert property (@(posedge clk) disable iff (!rstN) orderViolation |-> execReq.execute);

endmodule

/* src/MemTagAccessStage.sv */
// Memory tag access stage top level
// One load lane and one store lane, each with its own flush check

`timescale 1ns/1ns
`include "memTag_settings.svh"

module MemTagAccessStage (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic clear,
    input  MemTagPkg::memTagEntry_t ldIn,
    input  MemTagPkg::memTagEntry_t stIn,
    input  MemTagPkg::flushRequest_t flushReq,
    input  MemTagPkg::loadTagResult_t ldResult,
    input  logic stConflict,
    output MemTagPkg::memAccessOut_t ldOut,
    output MemTagPkg::memAccessOut_t stOut,
    output MemTagPkg::replayRecord_t ldRecord,
    output MemTagPkg::replayRecord_t stRecord,
    output MemTagPkg::loadExecReq_t ldExec,
    output MemTagPkg::storeExecReq_t stExec,
    output logic [`MT_MSHR_NUM-1:0] mshrRelease,
    output logic orderViolation
);
    import MemTagPkg::*;

    logic [`MT_AL_PTR_WIDTH-1:0] ldPtr;
    logic [`MT_AL_PTR_WIDTH-1:0] stPtr;
    logic ldFlush;
    logic stFlush;

    FlushRangeCheck i_ldFlushCheck (.flushReq(flushReq), .ptr(ldPtr), .flush(ldFlush));
    FlushRangeCheck i_stFlushCheck (.flushReq(flushReq), .ptr(stPtr), .flush(stFlush));

    LoadTagLane i_LoadTagLane (
        .clk(clk), .rstN(rstN), .stall(stall), .clear(clear), .flush(ldFlush),
        .entryIn(ldIn), .tagResult(ldResult), .activeListPtr(ldPtr),
        .execReq(ldExec), .out(ldOut), .record(ldRecord), .mshrRelease(mshrRelease)
    );

    StoreTagLane i_StoreTagLane (
        .clk(clk), .rstN(rstN), .stall(stall), .clear(clear), .flush(stFlush),
        .entryIn(stIn), .conflict(stConflict), .activeListPtr(stPtr),
        .execReq(stExec), .out(stOut), .record(stRecord), .orderViolation(orderViolation)
    );

endmodule

/* verification/MemTagAccessTb.sv */
// Testbench for the memory tag access stage
// Drives load and store entries with tag results and flush controls,
// then compares every lane output against reference models

`timescale 1ns/1ns
`include "memTag_settings.svh"

module MemTagAccessTb;
    import MemTagPkg::*;

    // About twice the cycles that the tests take
    localparam int CycleLimit = 600;

    logic clk;
    logic rstN;
    logic stall;
    logic clear;
    memTagEntry_t ldIn;
    memTagEntry_t stIn;
    flushRequest_t flushReq;
    loadTagResult_t ldResult;
    logic stConflict;
    memAccessOut_t ldOut;
    memAccessOut_t stOut;
    replayRecord_t ldRecord;
    replayRecord_t stRecord;
    loadExecReq_t ldExec;
    storeExecReq_t stExec;
    logic [`MT_MSHR_NUM-1:0] mshrRelease;
    logic orderViolation;

    // Expected values for the entries now held in the stage
    memAccessOut_t expLdOut;
    memAccessOut_t expStOut;
    replayRecord_t expLdRecord;
    replayRecord_t expStRecord;
    logic [`MT_MSHR_NUM-1:0] expRelease;
    loadExecReq_t expLdExec;
    storeExecReq_t expStExec;
    logic expViolation;
    logic checkNow = 1'b0;
    int errors = 0;
    int cycles = 0;

    MemTagAccessStage i_MemTagAccessStage (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic coin(input int pct);
        return $urandom_range(99, 0) < pct;
    endfunction

    function automatic logic misaligned(input logic [`MT_ADDR_WIDTH-1:0] addr,
                                        input accessSize_e size);
        return (size == SIZE_HALF && addr[0]) || (size == SIZE_WORD && addr[1:0] != 2'b00);
    endfunction

    // Distance from head, modulo list size, compared with the range length
    function automatic logic inFlushRange(input flushRequest_t f,
                                          input logic [`MT_AL_PTR_WIDTH-1:0] ptr);
        logic [`MT_AL_PTR_WIDTH-1:0] offset;
        logic [`MT_AL_PTR_WIDTH-1:0] span;
        offset = ptr - f.headPtr;
        span = f.tailPtr - f.headPtr;
        return f.toRecoveryPhase && (f.flushAll || offset < span);
    endfunction

    function automatic void expectLoad(
        input memTagEntry_t e, input loadTagResult_t r, input logic stl, input logic clr,
        input logic flushed, output memAccessOut_t o, output replayRecord_t rec,
        output logic [`MT_MSHR_NUM-1:0] rel
    );
        logic upd;
        logic load;
        logic mshr;
        logic vld;
        logic [`MT_MSHR_ID_WIDTH-1:0] id;
        execState_e st;
        upd = e.valid && !stl && !clr && !flushed;
        load = e.opType == MOP_LOAD;
        mshr = e.hasAllocatedMshr || r.loadHasAllocatedMshr;
        if (e.hasAllocatedMshr) id = e.mshrId;
        else if (r.loadHasAllocatedMshr) id = r.allocMshrId;
        else if (r.mshrAddrHit) id = r.hitMshrId;
        else id = e.mshrId;
        if (!load) vld = mshr ? r.mshrReadHit : e.regValid;
        else if (r.storeLoadForwarded) vld = !r.forwardMiss && e.regValid;
        else if (mshr) vld = r.mshrReadHit && e.regValid;
        else vld = (r.mshrReadHit || r.dcReadHit) && e.regValid;
        st = SUCCESS;
        if (!(upd && vld)) begin
            st = NOT_FINISHED;
        end else if (load) begin
            st = (r.storeLoadForwarded && r.forwardMiss) ? REFETCH_THIS : SUCCESS;
        end else if (e.opType == MOP_ENV) begin
            case (e.envCode)
                ENV_CALL:      st = TRAP_ECALL;
                ENV_MRET:      st = TRAP_MRET;
                ENV_ILLEGAL:   st = FAULT_INSN_ILLEGAL;
                ENV_VIOLATION: st = FAULT_INSN_VIOLATION;
                default:       st = TRAP_EBREAK;
            endcase
        end else if (e.opType == MOP_FENCE && e.isFenceI) begin
            st = REFETCH_NEXT;
        end
        if (load && (st == SUCCESS || st == REFETCH_NEXT)) begin
            if (e.memMapType == MMT_ILLEGAL) st = FAULT_LOAD_VIOLATION;
            else if (misaligned(e.addr, e.size)) st = FAULT_LOAD_MISALIGNED;
        end
        o = '{valid: upd, regValid: vld, execState: st, isLoad: load, isStore: 1'b0,
              addr: e.addr, activeListPtr: e.activeListPtr, pc: e.pc, data: e.data};
        rec = '{record: upd && !vld, addrHit: r.mshrAddrHit, addrSubset: e.addr[6:4],
                hasAllocatedMshr: mshr, mshrId: id, activeListPtr: e.activeListPtr, pc: e.pc};
        rel = '0;
        if ((upd && vld && load && r.storeLoadForwarded && mshr) ||
            (e.valid && load && flushed && mshr)) rel[id] = 1'b1;
    endfunction

    function automatic void expectStore(
        input memTagEntry_t e, input logic conflict, input logic stl, input logic clr,
        input logic flushed, output memAccessOut_t o, output replayRecord_t rec,
        output logic viol
    );
        logic upd;
        logic store;
        execState_e st;
        upd = e.valid && !stl && !clr && !flushed;
        store = e.opType == MOP_STORE;
        viol = upd && e.regValid && store && conflict;
        if (!(upd && e.regValid)) st = NOT_FINISHED;
        else st = (store && conflict) ? REFETCH_NEXT : SUCCESS;
        if (store && (st == SUCCESS || st == REFETCH_NEXT)) begin
            if (e.memMapType == MMT_ILLEGAL) st = FAULT_STORE_VIOLATION;
            else if (misaligned(e.addr, e.size)) st = FAULT_STORE_MISALIGNED;
        end
        o = '{valid: upd, regValid: e.regValid, execState: st, isLoad: 1'b0, isStore: store,
              addr: e.addr, activeListPtr: e.activeListPtr, pc: e.pc, data: e.data};
        rec = '{record: upd && !e.regValid, addrHit: 1'b0, addrSubset: e.addr[6:4],
                hasAllocatedMshr: 1'b0, mshrId: '0, activeListPtr: e.activeListPtr, pc: e.pc};
    endfunction

    function automatic memTagEntry_t randEntry(input memOpType_e op);
        memTagEntry_t e;
        logic [31:0] rnd;
        rnd = $urandom;
        e = '0;
        e.valid = 1'b1;
        e.regValid = 1'b1;
        e.opType = op;
        e.size = accessSize_e'(rnd[1:0] % 2'd3);
        e.addr = $urandom;
        e.activeListPtr = rnd[13:8];
        e.pc = $urandom;
        e.data = $urandom;
        e.mshrId = rnd[17:16];
        return e;
    endfunction

    function automatic loadTagResult_t randResult();
        logic [31:0] rnd;
        rnd = $urandom;
        return loadTagResult_t'(rnd[9:0]);
    endfunction

    // Entry goes in at the first edge, its tag results and controls at the next
    task automatic runTest(input memTagEntry_t ld, input loadTagResult_t res,
                           input memTagEntry_t st, input logic conflict,
                           input flushRequest_t f, input logic stl, input logic clr);
        @(posedge clk);
        checkNow = 1'b0;
        ldIn <= ld;
        stIn <= st;
        stall <= 1'b0;
        clear <= 1'b0;
        flushReq <= '0;
        ldResult <= '0;
        stConflict <= 1'b0;
        @(posedge clk);
        ldResult <= res;
        stConflict <= conflict;
        flushReq <= f;
        stall <= stl;
        clear <= clr;
        expectLoad(ld, res, stl, clr, inFlushRange(f, ld.activeListPtr),
                   expLdOut, expLdRecord, expRelease);
        expectStore(st, conflict, stl, clr, inFlushRange(f, st.activeListPtr),
                    expStOut, expStRecord, expViolation);
        expLdExec = '{execute: expLdOut.valid && ld.opType == MOP_LOAD, addr: ld.addr,
                      pc: ld.pc, size: ld.size, regValid: expLdOut.regValid};
        expStExec = '{execute: expStOut.valid && st.opType == MOP_STORE, addr: st.addr,
                      data: st.data, size: st.size, regValid: st.regValid};
        checkNow = 1'b1;
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (checkNow) begin
            if (ldOut !== expLdOut) begin
                $display("FAIL %0t ldOut got %h expected %h", $time, ldOut, expLdOut);
                errors++;
            end
            if (stOut !== expStOut) begin
                $display("FAIL %0t stOut got %h expected %h", $time, stOut, expStOut);
                errors++;
            end
            if (ldRecord !== expLdRecord) begin
                $display("FAIL %0t ldRecord got %h expected %h", $time, ldRecord, expLdRecord);
                errors++;
            end
            if (stRecord !== expStRecord) begin
                $display("FAIL %0t stRecord got %h expected %h", $time, stRecord, expStRecord);
                errors++;
            end
            if (ldExec !== expLdExec) begin
                $display("FAIL %0t ldExec got %h expected %h", $time, ldExec, expLdExec);
                errors++;
            end
            if (stExec !== expStExec) begin
                $display("FAIL %0t stExec got %h expected %h", $time, stExec, expStExec);
                errors++;
            end
            if (mshrRelease !== expRelease) begin
                $display("FAIL %0t mshrRelease got %b expected %b", $time, mshrRelease,
                         expRelease);
                errors++;
            end
            if (orderViolation !== expViolation) begin
                $display("FAIL %0t orderViolation got %b expected %b", $time, orderViolation,
                         expViolation);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("Errors: %0d", errors);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        memTagEntry_t ld;
        memTagEntry_t st;
        loadTagResult_t res;
        flushRequest_t f;
        logic [31:0] rnd;
        void'($urandom(49329));
        rstN = 1'b0;
        stall = 1'b0;
        clear = 1'b0;
        ldIn = '0;
        stIn = '0;
        flushReq = '0;
        ldResult = '0;
        stConflict = 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        // Idle stage right after reset
        runTest('0, '0, '0, 1'b0, '0, 1'b0, 1'b0);

        // Cache hit, miss and MSHR paths
        repeat (50) begin
            ld = randEntry(MOP_LOAD);
            ld.regValid = coin(80);
            ld.hasAllocatedMshr = coin(30);
            st = randEntry(MOP_STORE);
            runTest(ld, randResult(), st, coin(20), '0, 1'b0, 1'b0);
        end

        // Forwarded loads, some flushed while holding an MSHR
        for (int i = 0; i < 20; i++) begin
            ld = randEntry(MOP_LOAD);
            ld.hasAllocatedMshr = coin(50);
            res = randResult();
            res.storeLoadForwarded = 1'b1;
            res.forwardMiss = coin(50);
            f = '0;
            if (i % 3 == 0) begin
                f.toRecoveryPhase = 1'b1;
                f.headPtr = ld.activeListPtr;
                f.tailPtr = ld.activeListPtr + 1'b1;
            end
            runTest(ld, res, randEntry(MOP_STORE), 1'b0, f, 1'b0, 1'b0);
        end

        // Every env code, then FENCE.I, plain fence and other ops
        for (int i = 0; i < 8; i++) begin
            ld = randEntry(i < 5 ? MOP_ENV : (i < 7 ? MOP_FENCE : MOP_OTHER));
            ld.envCode = envCode_e'(i % 5);
            ld.isFenceI = (i == 5);
            runTest(ld, '0, ld, 1'b0, '0, 1'b0, 1'b0);
        end

        // Region and alignment faults on both lanes
        repeat (24) begin
            ld = randEntry(MOP_LOAD);
            ld.memMapType = memMapType_e'($urandom_range(2, 0));
            st = randEntry(MOP_STORE);
            st.memMapType = memMapType_e'($urandom_range(2, 0));
            res = '0;
            res.dcReadHit = 1'b1;
            runTest(ld, res, st, coin(30), '0, 1'b0, 1'b0);
        end

        // Order violations and store replays
        repeat (16) begin
            st = randEntry(MOP_STORE);
            st.regValid = coin(60);
            runTest(randEntry(MOP_LOAD), randResult(), st, coin(60), '0, 1'b0, 1'b0);
        end

        // Plain and wrapped flush ranges mixed with stall and clear
        repeat (30) begin
            ld = randEntry(MOP_LOAD);
            ld.hasAllocatedMshr = coin(50);
            rnd = $urandom;
            f.toRecoveryPhase = coin(80);
            f.flushAll = coin(20);
            f.headPtr = rnd[5:0];
            f.tailPtr = rnd[11:6];
            runTest(ld, randResult(), randEntry(MOP_STORE), coin(50), f, coin(20), coin(20));
        end

        @(posedge clk);
        checkNow = 1'b0;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+src
src/MemTagPkg.sv
src/FlushRangeCheck.sv
src/LoadTagLane.sv
src/StoreTagLane.sv
src/MemTagAccessStage.sv
verification/MemTagAccessTb.sv

/* Makefile */
TOP = MemTagAccessTb

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean
